// ==== files.f ====
+incdir+include
+incdir+verification
hw/lease_pkg.sv
hw/lease_lookup_if.sv
hw/lfsr_9b.sv
hw/lease_lookup_table.sv
hw/lease_probability_selector.sv
hw/set_expiry_encoder.sv
hw/lease_policy_controller.sv
hw/lease_policy_top.sv
verification/lease_policy_tb.sv

// ==== Makefile ====
# Verilator build and run of the lease policy testbench

SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = lease_policy_tb
FILELIST = files.f
OBJDIR   = obj_dir

.PHONY: sim clean

# the run passes only if the pass line shows up in the output
sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -q "RESULT: PASS"

clean:
	rm -rf $(OBJDIR)

// ==== include/lease_tb_cfg.svh ====
// ----------------------------------------------------------
// run constants for the lease policy testbench
// included inside the testbench module, holds no logic
// ----------------------------------------------------------
`ifndef LEASE_TB_CFG_SVH
`define LEASE_TB_CFG_SVH

// seed for $urandom, picks the unused table addresses
`define LEASE_TB_SEED        94716

`define LEASE_TB_LLT_SIZE    8     // lookup table entries the tb may load
`define LEASE_TB_OP_TIMEOUT  20    // watchdog cycles per stimulus row

`endif

// ==== verification/lease_policy_checks.svh ====
// ----------------------------------------------------------
// typed compare tasks and table loading for the lease tb
// ----------------------------------------------------------
`ifndef LEASE_POLICY_CHECKS_SVH
`define LEASE_POLICY_CHECKS_SVH

// first mismatch ends the run
task automatic report_fail(input string msg);
	$display("FAIL t=%0t %s", $time, msg);
	$display("RESULT: FAIL");
	$fatal(1, "lease policy tb stopped on a mismatch");
endtask

task automatic check_line_addr(input line_addr_t got, input line_addr_t exp, input string what);
	if (got !== exp) report_fail($sformatf("%s got %0d expected %0d", what, got, exp));
endtask

// random victim, only the set bits are predictable
task automatic check_victim_set(input line_addr_t got, input set_t exp, input string what);
	if (got[1:0] !== exp) report_fail($sformatf("%s set %0d expected %0d", what, got[1:0], exp));
endtask

task automatic check_flag(input logic got, input logic exp, input string what);
	if (got !== exp) report_fail($sformatf("%s got %b expected %b", what, got, exp));
endtask

task automatic check_done(input logic got, input logic exp, input string what);
	if (got !== exp) report_fail($sformatf("%s done got %b expected %b", what, got, exp));
endtask

// one table word, address is {bank, entry}
task automatic write_llt(input llt_bank_t bank, input llt_idx_t idx, input data_t data);
	@(posedge clock_i);
	wren_i  <= 1'b1;
	waddr_i <= {bank, idx};
	wdata_i <= data;
	@(posedge clock_i);
	wren_i  <= 1'b0;
endtask

task automatic write_default_lease(input lease_t lease);
	@(posedge clock_i);
	con_wren_i <= 1'b1;
	waddr_i    <= CFG_DEFAULT_ADDR;
	wdata_i    <= data_t'(lease);
	@(posedge clock_i);
	con_wren_i <= 1'b0;
endtask

task automatic load_table();
	for (int i = 0; i < `LEASE_TB_LLT_SIZE; i++) begin
		write_llt(LLT_BANK_LEASE0, llt_idx_t'(i), data_t'(ent_l0[i]));
		write_llt(LLT_BANK_LEASE1, llt_idx_t'(i), data_t'(ent_l1[i]));
		write_llt(LLT_BANK_PROB, llt_idx_t'(i), data_t'(ent_prob[i]));
		write_llt(LLT_BANK_REF, llt_idx_t'(i), data_t'(ent_ref[i]));  // validates last
	end
endtask

`endif

// ==== verification/lease_policy_tb.sv ====
// ----------------------------------------------------------
// testbench for the lease replacement top, runs a table of
// hit/miss operations and checks every replacement result
// ----------------------------------------------------------
module lease_policy_tb;
	import lease_pkg::*;

	`include "lease_tb_cfg.svh"

	logic       clock_i, resetn_i;
	logic       wren_i, con_wren_i, hit_i, miss_i;
	llt_addr_t  waddr_i;
	data_t      wdata_i;
	word_addr_t search_addr_i;
	line_addr_t cache_addr_i;
	logic       done_o, swap_o, expired_o, expired_multi_o, default_o, rand_evict_o;
	line_addr_t addr_o;

	// table entry contents
	word_addr_t ent_ref  [`LEASE_TB_LLT_SIZE];
	lease_t     ent_l0   [`LEASE_TB_LLT_SIZE];
	lease_t     ent_l1   [`LEASE_TB_LLT_SIZE];
	prob_t      ent_prob [`LEASE_TB_LLT_SIZE];
	word_addr_t stray_addr;  // listed in no entry

	typedef struct {
		logic       is_miss;
		word_addr_t saddr;
		line_addr_t caddr;
		int         lat;        // cycles from strobe edge to result
		logic       swap;
		line_addr_t addr;       // expected victim or held value
		logic [3:0] flags;      // {expired, multi, default, rand}
	} op_t;

	op_t ops [$];

	`include "lease_policy_checks.svh"

	lease_policy_top i_lease_policy_top (.*);

	always #5 clock_i = ~clock_i;

	function automatic logic addr_taken(input word_addr_t a, input int upto);
		for (int i = 0; i < upto; i++) begin
			if (ent_ref[i] == a) return 1'b1;
		end
		return 1'b0;
	endfunction

	// one fixed table entry
	function automatic void set_entry(input int idx, input word_addr_t ref_addr,
		input lease_t l0, input lease_t l1, input prob_t prob);
		ent_ref[idx]  = ref_addr;
		ent_l0[idx]   = l0;
		ent_l1[idx]   = l1;
		ent_prob[idx] = prob;
	endfunction

	// latency follows from kind, a swapping miss takes one extra cycle
	task automatic add_op(input logic is_miss, input word_addr_t saddr, input line_addr_t caddr,
		input logic swap, input line_addr_t addr, input logic [3:0] flags);
		op_t op;
		op.is_miss = is_miss;
		op.saddr   = saddr;
		op.caddr   = caddr;
		op.swap    = swap;
		op.addr    = addr;
		op.flags   = flags;
		op.lat     = (is_miss && swap) ? 2 : 1;
		ops.push_back(op);
	endtask

	// ----------------------------------------------------------
	// watchdog
	// ----------------------------------------------------------
	initial begin
		#1;
		repeat (ops.size() * `LEASE_TB_OP_TIMEOUT) @(posedge clock_i);
		$display("watchdog: run did not finish within %0d cycles",
			ops.size() * `LEASE_TB_OP_TIMEOUT);
		$display("RESULT: FAIL");
		$fatal(1, "watchdog expired");
	end

	initial begin
		op_t op;
		clock_i       = 1'b0;
		resetn_i      = 1'b0;
		wren_i        = 1'b0;
		con_wren_i    = 1'b0;
		hit_i         = 1'b0;
		miss_i        = 1'b0;
		waddr_i       = '0;
		wdata_i       = '0;
		search_addr_i = '0;
		cache_addr_i  = '0;
		void'($urandom(`LEASE_TB_SEED));

		// fixed entries given as ref, lease0, lease1 and prob
		set_entry(0, 16'h0100, 8'd40, 8'd40, 9'd511);
		set_entry(1, 16'h0200, 8'd0,  8'd30, 9'd511);
		set_entry(2, 16'h0300, 8'd1,  8'd50, 9'd511);
		set_entry(3, 16'h0400, 8'd50, 8'd3,  9'd0);
		for (int i = 4; i < `LEASE_TB_LLT_SIZE; i++) begin
			do ent_ref[i] = word_addr_t'($urandom); while (addr_taken(ent_ref[i], i));
			ent_l0[i]   = 8'd9;
			ent_l1[i]   = 8'd9;
			ent_prob[i] = 9'd256;
		end
		do stray_addr = word_addr_t'($urandom);
		while (addr_taken(stray_addr, `LEASE_TB_LLT_SIZE));

		// cold start of set 2, each miss with its follow-up hit
		add_op(1'b1, ent_ref[0], 4'd2,  1'b1, 4'd2,  4'b0000);
		add_op(1'b0, ent_ref[0], 4'd2,  1'b0, 4'd2,  4'b0000);
		add_op(1'b1, ent_ref[0], 4'd2,  1'b1, 4'd6,  4'b0000);
		add_op(1'b0, ent_ref[0], 4'd6,  1'b0, 4'd6,  4'b0000);
		add_op(1'b1, ent_ref[0], 4'd2,  1'b1, 4'd10, 4'b0000);
		add_op(1'b0, ent_ref[0], 4'd10, 1'b0, 4'd10, 4'b0000);
		add_op(1'b1, ent_ref[0], 4'd2,  1'b1, 4'd14, 4'b0000);
		add_op(1'b0, ent_ref[0], 4'd14, 1'b0, 4'd14, 4'b0000);
		// zero lease bypass, table entry then default lease
		add_op(1'b1, ent_ref[1], 4'd2,  1'b0, 4'd14, 4'b0000);
		add_op(1'b1, stray_addr, 4'd2,  1'b0, 4'd14, 4'b0010);
		// line 6 gets primary 1, line 10 secondary 3
		add_op(1'b0, ent_ref[2], 4'd6,  1'b0, 4'd14, 4'b0000);
		add_op(1'b0, ent_ref[3], 4'd10, 1'b0, 4'd14, 4'b0000);
		add_op(1'b1, ent_ref[0], 4'd2,  1'b1, 4'd6,  4'b1000);  // only way 1 expired
		add_op(1'b0, ent_ref[0], 4'd6,  1'b0, 4'd6,  4'b0000);
		add_op(1'b0, stray_addr, 4'd1,  1'b0, 4'd6,  4'b0010);  // default hits count down
		add_op(1'b0, stray_addr, 4'd5,  1'b0, 4'd6,  4'b0010);  // line 10 reaches 0 here
		add_op(1'b0, ent_ref[2], 4'd2,  1'b0, 4'd6,  4'b0000);
		add_op(1'b1, ent_ref[0], 4'd2,  1'b1, 4'd2,  4'b1100);  // ways 0 and 2 expired
		add_op(1'b0, ent_ref[0], 4'd2,  1'b0, 4'd2,  4'b0000);
		add_op(1'b1, ent_ref[0], 4'd2,  1'b1, 4'd10, 4'b1000);
		add_op(1'b0, ent_ref[0], 4'd10, 1'b0, 4'd10, 4'b0000);
		// every way of set 2 alive, random victim
		add_op(1'b1, ent_ref[0], 4'd2,  1'b1, 4'd2,  4'b0001);

		repeat (5) @(posedge clock_i);
		resetn_i <= 1'b1;
		load_table();
		write_default_lease(8'd0);

		// ----------------------------------------------------------
		// operation loop
		// ----------------------------------------------------------
		foreach (ops[i]) begin
			op = ops[i];
			@(posedge clock_i);
			hit_i         <= !op.is_miss;
			miss_i        <= op.is_miss;
			search_addr_i <= op.saddr;
			cache_addr_i  <= op.caddr;
			@(posedge clock_i);  // strobe taken here
			hit_i  <= 1'b0;
			miss_i <= 1'b0;
			if (op.lat == 2) begin
				@(negedge clock_i);
				check_done(done_o, 1'b0, $sformatf("row %0d replace cycle", i));
				@(posedge clock_i);
			end
			@(negedge clock_i);
			check_done(done_o, op.is_miss, $sformatf("row %0d", i));
			check_flag(swap_o, op.swap, $sformatf("row %0d swap_o", i));
			if (op.flags[0]) begin
				check_victim_set(addr_o, set_t'(op.caddr[1:0]), $sformatf("row %0d addr_o", i));
			end else begin
				check_line_addr(addr_o, op.addr, $sformatf("row %0d addr_o", i));
			end
			check_flag(expired_o, op.flags[3], $sformatf("row %0d expired_o", i));
			check_flag(expired_multi_o, op.flags[2], $sformatf("row %0d expired_multi_o", i));
			check_flag(default_o, op.flags[1], $sformatf("row %0d default_o", i));
			check_flag(rand_evict_o, op.flags[0], $sformatf("row %0d rand_evict_o", i));
		end

		repeat (2) @(posedge clock_i);
		$display("RESULT: PASS");
		$finish;
	end

endmodule

// ==== hw/lease_policy_top.sv ====
// ----------------------------------------------------------
// lease replacement subsystem top, table + lease selector +
// controller behind the cache controller's plain ports
// ----------------------------------------------------------
module lease_policy_top (
	input  logic                  clock_i,
	input  logic                  resetn_i,
	// write bus from the cache controller
	input  logic                  wren_i,          // lookup table write
	input  logic                  con_wren_i,      // configuration write
	input  lease_pkg::llt_addr_t  waddr_i,
	input  lease_pkg::data_t      wdata_i,
	// access strobes
	input  lease_pkg::word_addr_t search_addr_i,
	input  lease_pkg::line_addr_t cache_addr_i,
	input  logic                  hit_i,
	input  logic                  miss_i,
	// replacement result
	output logic                  done_o,
	output lease_pkg::line_addr_t addr_o,
	output logic                  swap_o,
	output logic                  expired_o,
	output logic                  expired_multi_o,
	output logic                  default_o,
	output logic                  rand_evict_o
);
	import lease_pkg::*;

	lease_lookup_if lookup_bus ();  // search and its result

	lease_t sel_lease;  // drawn lease for this access
	logic   advance;

	lease_lookup_table i_lookup_table (
		.clock_i  (clock_i),
		.resetn_i (resetn_i),
		.wren_i   (wren_i),
		.waddr_i  (waddr_i),
		.wdata_i  (wdata_i),
		.lookup   (lookup_bus.tbl)
	);

	lease_probability_selector i_selector (
		.clock_i   (clock_i),
		.resetn_i  (resetn_i),
		.advance_i (advance),
		.lookup    (lookup_bus.selector),
		.lease_o   (sel_lease)
	);

	lease_policy_controller i_controller (
		.clock_i         (clock_i),
		.resetn_i        (resetn_i),
		.con_wren_i      (con_wren_i),
		.waddr_i         (waddr_i),
		.wdata_i         (wdata_i),
		.search_addr_i   (search_addr_i),
		.cache_addr_i    (cache_addr_i),
		.hit_i           (hit_i),
		.miss_i          (miss_i),
		.lookup          (lookup_bus.ctrl),
		.lease_i         (sel_lease),
		.advance_o       (advance),
		.done_o          (done_o),
		.addr_o          (addr_o),
		.swap_o          (swap_o),
		.expired_o       (expired_o),
		.expired_multi_o (expired_multi_o),
		.default_o       (default_o),
		.rand_evict_o    (rand_evict_o)
	);

endmodule

// ==== hw/lease_policy_controller.sv ====
// ----------------------------------------------------------
// lease registers and hit/miss fsm, renews leases on hits and
// picks victims on misses (cold start, expired, random)
// ----------------------------------------------------------
module lease_policy_controller (
	input  logic                  clock_i,
	input  logic                  resetn_i,
	input  logic                  con_wren_i,     // configuration write
	input  lease_pkg::llt_addr_t  waddr_i,
	input  lease_pkg::data_t      wdata_i,
	input  lease_pkg::word_addr_t search_addr_i,  // reference of this access
	input  lease_pkg::line_addr_t cache_addr_i,   // translated line
	input  logic                  hit_i,
	input  logic                  miss_i,
	lease_lookup_if.ctrl          lookup,
	input  lease_pkg::lease_t     lease_i,        // drawn lease from the selector
	output logic                  advance_o,      // step the probability lfsr
	output logic                  done_o,
	output lease_pkg::line_addr_t addr_o,         // victim line, held until next one
	output logic                  swap_o,
	output logic                  expired_o,
	output logic                  expired_multi_o,
	output logic                  default_o,
	output logic                  rand_evict_o
);
	import lease_pkg::*;

	ctrl_state_t       state_q;
	lease_t            leases_q   [N_LINES];  // one lease per cache line
	lease_t            leases_dec [N_LINES];  // all leases one step later
	way_t              cold_cnt_q [N_SETS];   // next unused way per set
	logic [N_SETS-1:0] full_q;                // set filled by cold start
	lease_t            default_lease_q;
	lease_t            saved_lease_q;         // lease for the follow-up hit
	set_t              miss_set_q;            // set of the pending miss
	logic              followup_q;            // next hit completes a miss

	logic       done_q, swap_q, expired_q, multi_q, default_q, rand_q;
	line_addr_t addr_q;

	set_t   acc_set;
	lease_t new_lease;
	way_t   exp_way;
	logic   exp_found, exp_multi;
	prob_t  evict_rand;
	logic   evict_step;

	assign lookup.search_addr = search_addr_i;
	assign advance_o = hit_i || miss_i;  // fresh draw after every access

	assign acc_set   = cache_addr_i[$bits(set_t)-1:0];
	assign new_lease = lookup.hit ? lease_i : default_lease_q;  // table or default

	// countdown, an expired line stays at zero
	always_comb begin
		for (int i = 0; i < N_LINES; i++) begin
			leases_dec[i] = (leases_q[i] != '0) ? leases_q[i] - 1'b1 : leases_q[i];
		end
	end

	// ----------------------------------------------------------
	// victim sources
	// ----------------------------------------------------------
	set_expiry_encoder i_expiry (
		.leases_i (leases_q),
		.set_i    (miss_set_q),
		.way_o    (exp_way),
		.found_o  (exp_found),
		.multi_o  (exp_multi)
	);

	// random fallback only steps when it is actually taken
	assign evict_step = (state_q == ST_REPLACE) && full_q[miss_set_q] && !exp_found;

	lfsr_9b i_evict_lfsr (
		.clock_i  (clock_i),
		.resetn_i (resetn_i),
		.enable_i (evict_step),
		.seed_i   (LFSR_SEED_EVICT),
		.value_o  (evict_rand)
	);

	// default lease register
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			default_lease_q <= '0;
		end else if (con_wren_i && waddr_i == CFG_DEFAULT_ADDR) begin
			default_lease_q <= wdata_i[$bits(lease_t)-1:0];
		end
	end

	// pending miss payload
	always_ff @(posedge clock_i) begin
		if (state_q == ST_IDLE && miss_i) begin
			saved_lease_q <= new_lease;
			miss_set_q    <= acc_set;
		end
	end

	// ----------------------------------------------------------
	// hit/miss fsm
	// ----------------------------------------------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			state_q    <= ST_IDLE;
			followup_q <= 1'b0;
			full_q     <= '0;
			for (int i = 0; i < N_LINES; i++) leases_q[i] <= '0;
			for (int s = 0; s < N_SETS; s++) cold_cnt_q[s] <= '0;
			done_q    <= 1'b0;
			swap_q    <= 1'b0;
			expired_q <= 1'b0;
			multi_q   <= 1'b0;
			default_q <= 1'b0;
			rand_q    <= 1'b0;
			addr_q    <= '0;
		end else begin
			done_q    <= 1'b0;  // result flags are single cycle
			swap_q    <= 1'b0;
			expired_q <= 1'b0;
			multi_q   <= 1'b0;
			default_q <= 1'b0;
			rand_q    <= 1'b0;
			case (state_q)
				ST_IDLE: begin
					if (hit_i) begin
						if (followup_q) begin
							followup_q             <= 1'b0;           // countdown done at the miss
							leases_q[cache_addr_i] <= saved_lease_q;
						end else begin
							leases_q               <= leases_dec;
							leases_q[cache_addr_i] <= new_lease;      // renewal wins over countdown
							default_q              <= !lookup.hit;
						end
					end else if (miss_i) begin
						leases_q  <= leases_dec;
						default_q <= !lookup.hit;
						if (new_lease != '0) begin
							state_q    <= ST_REPLACE;  // block is worth caching
							followup_q <= 1'b1;
						end else begin
							done_q <= 1'b1;            // bypass leaves swap low
						end
					end
				end
				ST_REPLACE: begin
					state_q <= ST_IDLE;
					done_q  <= 1'b1;
					swap_q  <= 1'b1;
					if (!full_q[miss_set_q]) begin
						// cold start, fill the ways in order
						addr_q                 <= {cold_cnt_q[miss_set_q], miss_set_q};
						cold_cnt_q[miss_set_q] <= cold_cnt_q[miss_set_q] + 1'b1;
						if (cold_cnt_q[miss_set_q] == way_t'(N_WAYS - 1)) begin
							full_q[miss_set_q] <= 1'b1;  // last way handed out
						end
					end else if (exp_found) begin
						addr_q    <= {exp_way, miss_set_q};
						expired_q <= 1'b1;
						multi_q   <= exp_multi;
					end else begin
						addr_q <= {evict_rand[2:1], miss_set_q};  // nothing expired
						rand_q <= 1'b1;
					end
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	assign done_o          = done_q;
	assign addr_o          = addr_q;
	assign swap_o          = swap_q;
	assign expired_o       = expired_q;
	assign expired_multi_o = multi_q;
	assign default_o       = default_q;
	assign rand_evict_o    = rand_q;

	// ----------------------------------------------------------
	// strobe protocol
	// ----------------------------------------------------------
	a_strobe_excl: assert property (@(posedge clock_i) disable iff (!resetn_i)
		!(hit_i && miss_i))
		else $error("controller: hit and miss strobed together");

	a_no_strobe_busy: assert property (@(posedge clock_i) disable iff (!resetn_i)
		(state_q == ST_REPLACE) |-> !(hit_i || miss_i))
		else $error("controller: strobe while a replacement is pending");

	// done only repeats if a new miss arrived in the done cycle
	a_done_pulse: assert property (@(posedge clock_i) disable iff (!resetn_i)
		(done_o && !miss_i) |=> !done_o)
		else $error("controller: done held longer than one cycle");

endmodule

// ==== hw/set_expiry_encoder.sv ====
// ----------------------------------------------------------
// expiry view of one set, gives the lowest expired way and
// whether one or more ways of the set have run out
// ----------------------------------------------------------
module set_expiry_encoder (
	input  lease_pkg::lease_t leases_i [lease_pkg::N_LINES],  // all lease registers
	input  lease_pkg::set_t   set_i,                          // set under replacement
	output lease_pkg::way_t   way_o,                          // lowest expired way
	output logic              found_o,                        // any way expired
	output logic              multi_o                         // two or more expired
);
	import lease_pkg::*;

	logic [N_WAYS-1:0] expired;  // one flag per way of the set

	// line address is {way, set}, so the set picks a stride of lines
	always_comb begin
		for (int w = 0; w < N_WAYS; w++) begin
			expired[w] = (leases_i[{way_t'(w), set_i}] == '0);
		end
	end

	// priority encode from way 0 upward
	always_comb begin
		way_o = '0;
		for (int w = N_WAYS - 1; w >= 0; w--) begin
			if (expired[w]) way_o = way_t'(w);
		end
	end

	assign found_o = |expired;

	// clearing the lowest set bit leaves something only if 2+ bits were set
	assign multi_o = |(expired & (expired - {{(N_WAYS-1){1'b0}}, 1'b1}));

endmodule

// ==== hw/lease_probability_selector.sv ====
// ----------------------------------------------------------
// draws lease0 or lease1 for the current lookup from a
// free running lfsr, stepped by the controller per access
// ----------------------------------------------------------
module lease_probability_selector (
	input  logic              clock_i,
	input  logic              resetn_i,
	input  logic              advance_i,  // hit or miss seen, draw a new value
	lease_lookup_if.selector  lookup,
	output lease_pkg::lease_t lease_o     // lease for the accessed line
);
	import lease_pkg::*;

	prob_t draw;  // 1..511, never 0

	lfsr_9b i_prob_lfsr (
		.clock_i  (clock_i),
		.resetn_i (resetn_i),
		.enable_i (advance_i),
		.seed_i   (LFSR_SEED_PROB),
		.value_o  (draw)
	);

	// prob 0 always loses the draw, prob 511 always wins it
	always_comb begin
		if (draw <= lookup.lease0_prob) begin
			lease_o = lookup.lease0;  // primary lease
		end else begin
			lease_o = lookup.lease1;  // secondary lease
		end
	end

endmodule

// ==== hw/lease_lookup_table.sv ====
// ----------------------------------------------------------
// lease lookup table, written by the cache controller and
// searched by reference address without a clock
// ----------------------------------------------------------
module lease_lookup_table (
	input  logic                 clock_i,
	input  logic                 resetn_i,
	input  logic                 wren_i,   // table write strobe
	input  lease_pkg::llt_addr_t waddr_i,  // {bank, entry}
	input  lease_pkg::data_t     wdata_i,
	lease_lookup_if.tbl          lookup
);
	import lease_pkg::*;

	// four banks, one slot per entry
	word_addr_t ref_addr_q [LLT_ENTRIES];
	lease_t     lease0_q   [LLT_ENTRIES];
	lease_t     lease1_q   [LLT_ENTRIES];
	prob_t      prob_q     [LLT_ENTRIES];
	logic [LLT_ENTRIES-1:0] valid_q;

	llt_bank_t wr_bank;
	llt_idx_t  wr_idx;
	logic [LLT_ENTRIES-1:0] match;
	llt_idx_t  match_idx;

	assign wr_bank = waddr_i[4:3];
	assign wr_idx  = waddr_i[2:0];

	// ----------------------------------------------------------
	// write side
	// ----------------------------------------------------------
	always_ff @(posedge clock_i) begin
		if (wren_i) begin
			case (wr_bank)
				LLT_BANK_REF:    ref_addr_q[wr_idx] <= wdata_i[$bits(word_addr_t)-1:0];
				LLT_BANK_LEASE0: lease0_q[wr_idx]   <= wdata_i[$bits(lease_t)-1:0];
				LLT_BANK_LEASE1: lease1_q[wr_idx]   <= wdata_i[$bits(lease_t)-1:0];
				default:         prob_q[wr_idx]     <= wdata_i[$bits(prob_t)-1:0];
			endcase
		end
	end

	// an entry counts once its reference address is known
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			valid_q <= '0;
		end else if (wren_i && wr_bank == LLT_BANK_REF) begin
			valid_q[wr_idx] <= 1'b1;
		end
	end

	// ----------------------------------------------------------
	// parallel search
	// ----------------------------------------------------------
	always_comb begin
		for (int i = 0; i < LLT_ENTRIES; i++) begin
			match[i] = valid_q[i] && (ref_addr_q[i] == lookup.search_addr);
		end
	end

	// lowest matching entry, only one is expected anyway
	always_comb begin
		match_idx = '0;
		for (int i = LLT_ENTRIES - 1; i >= 0; i--) begin
			if (match[i]) match_idx = llt_idx_t'(i);
		end
	end

	assign lookup.hit         = |match;
	assign lookup.lease0      = lease0_q[match_idx];
	assign lookup.lease1      = lease1_q[match_idx];
	assign lookup.lease0_prob = prob_q[match_idx];

	// duplicate reference addresses would make the answer ambiguous
	a_single_match: assert property (@(posedge clock_i) disable iff (!resetn_i)
		$onehot0(match))
		else $error("lookup table: search address matched more than one entry");

endmodule

// ==== hw/lfsr_9b.sv ====
// ----------------------------------------------------------
// 9-bit maximal length lfsr, x^9 + x^5 + 1, steps on enable
// ----------------------------------------------------------
module lfsr_9b (
	input  logic             clock_i,
	input  logic             resetn_i,
	input  logic             enable_i,  // one step per cycle while high
	input  lease_pkg::prob_t seed_i,    // loaded in reset, must be nonzero
	output lease_pkg::prob_t value_o
);
	import lease_pkg::*;

	prob_t lfsr_q;
	logic  feedback;

	assign feedback = lfsr_q[8] ^ lfsr_q[4];  // taps 9 and 5, fibonacci form

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			lfsr_q <= seed_i;
		end else if (enable_i) begin
			lfsr_q <= {lfsr_q[7:0], feedback};  // shift toward msb
		end
	end

	assign value_o = lfsr_q;  // never 0 once seeded

endmodule

// ==== hw/lease_lookup_if.sv ====
// ----------------------------------------------------------
// lookup bus between table, lease selector and controller
// ----------------------------------------------------------
interface lease_lookup_if;
	import lease_pkg::*;

	word_addr_t search_addr;   // reference address being looked up
	logic       hit;           // some valid entry matched
	lease_t     lease0;        // primary lease of the match
	lease_t     lease1;        // secondary lease of the match
	prob_t      lease0_prob;   // chance of taking lease0

	// table answers the search combinationally
	modport tbl (
		input  search_addr,
		output hit, lease0, lease1, lease0_prob
	);

	// selector only reads the entry payload
	modport selector (
		input lease0, lease1, lease0_prob
	);

	modport ctrl (
		output search_addr,
		input  hit
	);

endinterface

// ==== hw/lease_pkg.sv ====
// ----------------------------------------------------------
// geometry, vector types and fsm encoding shared by the
// lease replacement controller, imported by every block
// ----------------------------------------------------------
package lease_pkg;

	// cache geometry, fixed at 16 lines in 4 sets of 4 ways
	localparam int N_LINES     = 16;
	localparam int N_WAYS      = 4;
	localparam int N_SETS      = 4;
	localparam int LLT_ENTRIES = 8;    // lease lookup table depth

	// ----------------------------------------------------------
	// vector types
	// ----------------------------------------------------------
	typedef logic [3:0]  line_addr_t;  // {way, set}
	typedef logic [1:0]  way_t;
	typedef logic [1:0]  set_t;
	typedef logic [7:0]  lease_t;      // remaining lease of a line
	typedef logic [8:0]  prob_t;       // probability of lease0, also lfsr width
	typedef logic [15:0] word_addr_t;  // reference word address
	typedef logic [4:0]  llt_addr_t;   // {bank, entry}
	typedef logic [1:0]  llt_bank_t;
	typedef logic [2:0]  llt_idx_t;
	typedef logic [31:0] data_t;       // write bus word

	// table banks selected by waddr[4:3]
	localparam llt_bank_t LLT_BANK_REF   = 2'd0;  // writing this one validates the entry
	localparam llt_bank_t LLT_BANK_LEASE0 = 2'd1;
	localparam llt_bank_t LLT_BANK_LEASE1 = 2'd2;
	localparam llt_bank_t LLT_BANK_PROB  = 2'd3;

	// configuration space, written with con_wren
	localparam llt_addr_t CFG_DEFAULT_ADDR = 5'd0;

	// lfsr seeds, any nonzero value keeps the sequence alive
	localparam prob_t LFSR_SEED_PROB  = 9'h155;
	localparam prob_t LFSR_SEED_EVICT = 9'h0AB;

	// ----------------------------------------------------------
	// controller fsm
	// ----------------------------------------------------------
	typedef enum logic {
		ST_IDLE,     // waiting for hit or miss strobe
		ST_REPLACE   // picking a victim for the pending miss
	} ctrl_state_t;

endpackage
